// File: verilog.f
+incdir+include
design/read_config_pkg.sv
design/memory_request_pkg.sv
design/read_sequencer.sv
design/request_fifo.sv
design/request_issuer.sv
design/serial_read_engine.sv
bench/tb_serial_read_engine.sv

// File: Makefile
# Verilator flow for the serial read engine

VERILATOR ?= verilator
TOP       ?= tb_serial_read_engine
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_serial_read_engine.sv
// Directed testbench; the memory model holds mem_ack until mem_req drops and stride is nonzero

`timescale 1ns/1ps

`include "read_engine_macros.svh"

module tb_serial_read_engine;
    import read_config_pkg::*;
    import memory_request_pkg::*;

    localparam int timeout_cycles = 5000;

    logic         ap_clk;
    logic         areset_engine;
    read_config_t engine_config;
    logic         start;
    logic         pause;
    logic         mem_ack;
    logic         mem_req;
    mem_request_t mem_request;
    logic         ready;
    logic         done;

    mem_request_t captured [$];
    int           acks_done;
    int           mismatch_count;
    int           timeout_count;
    bit           random_delay;
    int           fixed_delay;

    serial_read_engine i_serial_read_engine (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .engine_config (engine_config),
        .start         (start),
        .pause         (pause),
        .mem_ack       (mem_ack),
        .mem_req       (mem_req),
        .mem_request   (mem_request),
        .ready         (ready),
        .done          (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #4 ap_clk = ~ap_clk;
        end
    end

    // ----------------------------------------
    // Memory responder
    // ----------------------------------------
    initial begin
        int wait_count;
        int delay;
        void'($urandom(81));
        forever begin
            @(posedge ap_clk);
            if (mem_req && !mem_ack) begin
                captured.push_back(mem_request);
                delay = random_delay ? int'($urandom % 6) : fixed_delay;
                repeat (delay) @(posedge ap_clk);
                #1 mem_ack = 1'b1;
                wait_count = 0;
                do begin
                    @(posedge ap_clk);
                    wait_count++;
                end while (mem_req && wait_count < timeout_cycles);
                if (mem_req) begin
                    $display("Timeout: mem_req stayed high after mem_ack");
                    timeout_count++;
                end
                #1 mem_ack = 1'b0;
                acks_done++;
            end
        end
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_request(input string name, input mem_request_t got,
                                 input mem_request_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic wait_done_level(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge ap_clk);
            cycles++;
        end while (done !== level && cycles < timeout_cycles);
        if (done !== level) begin
            $display("Timeout: done never reached level %0d", level);
            timeout_count++;
        end
    endtask

    task automatic wait_ready_high();
        int cycles;
        cycles = 0;
        do begin
            @(posedge ap_clk);
            cycles++;
        end while (ready !== 1'b1 && cycles < timeout_cycles);
        if (ready !== 1'b1) begin
            $display("Timeout: ready never rose");
            timeout_count++;
        end
    endtask

    // Byte offset predicted from shift or line and way rules
    function automatic logic [`READ_ENGINE_ADDR_WIDTH-1:0] expected_offset(
        input read_config_t cfg, input logic [`READ_ENGINE_INDEX_WIDTH-1:0] idx);
        logic [`READ_ENGINE_ADDR_WIDTH-1:0] wide;
        logic [`READ_ENGINE_ADDR_WIDTH-1:0] line;
        logic [`READ_ENGINE_ADDR_WIDTH-1:0] way;
        wide = {{(`READ_ENGINE_ADDR_WIDTH-`READ_ENGINE_INDEX_WIDTH){1'b0}}, idx};
        line = wide >> `READ_ENGINE_CACHE_WAYS_LOG;
        way  = wide % (64'd1 << `READ_ENGINE_CACHE_WAYS_LOG);
        if (cfg.flush_mode) begin
            return (line << (`READ_ENGINE_LINE_SIZE_LOG + `READ_ENGINE_CACHE_WAYS_LOG))
                | (way << `READ_ENGINE_LINE_SIZE_LOG);
        end
        if (cfg.shift_dir == SHIFT_LEFT) begin
            return wide << cfg.shift_amount;
        end
        return wide >> cfg.shift_amount;
    endfunction

    // ----------------------------------------
    // One full start/done run with checks
    // ----------------------------------------
    task automatic run_engine(input read_config_t cfg);
        mem_request_t                        exp_q [$];
        mem_request_t                        exp_req;
        logic [`READ_ENGINE_INDEX_WIDTH-1:0] idx;
        int                                  n;
        captured.delete();
        acks_done = 0;
        idx = cfg.start_read;
        while (idx < cfg.end_read) begin
            exp_req.base   = cfg.array_pointer;
            exp_req.offset = expected_offset(cfg, idx);
            exp_req.data   = idx;
            exp_q.push_back(exp_req);
            idx = idx + cfg.stride;
        end
        @(posedge ap_clk);
        #1;
        engine_config = cfg;
        start         = 1'b1;
        wait_done_level(1'b1);
        check_count("acks before done", acks_done, exp_q.size());
        check_count("request count", captured.size(), exp_q.size());
        n = (captured.size() < exp_q.size()) ? captured.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_request($sformatf("mem_request[%0d]", i), captured[i], exp_q[i]);
        end
        // done holds while start stays high
        repeat (2) @(posedge ap_clk);
        check_flag("done", done, 1'b1);
        #1 start = 1'b0;
        wait_done_level(1'b0);
        check_flag("ready", ready, 1'b1);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset();
        areset_engine = 1'b1;
        repeat (8) @(posedge ap_clk);
        check_flag("mem_req", mem_req, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("ready", ready, 1'b0);
        #1 areset_engine = 1'b0;
        wait_ready_high();
    endtask

    task automatic test_linear_left();
        read_config_t cfg;
        cfg = '0;
        cfg.array_pointer = 64'h0000_1000_0000_0000;
        cfg.start_read    = 32'd5;
        cfg.end_read      = 32'd25;
        cfg.stride        = 32'd1;
        cfg.shift_dir     = SHIFT_LEFT;
        cfg.shift_amount  = 5'd3;
        run_engine(cfg);
    endtask

    task automatic test_right_stride();
        read_config_t cfg;
        cfg = '0;
        cfg.array_pointer = 64'h0000_0000_8000_0040;
        cfg.start_read    = 32'd2;
        cfg.end_read      = 32'd50;
        cfg.stride        = 32'd3;
        cfg.shift_dir     = SHIFT_RIGHT;
        cfg.shift_amount  = 5'd1;
        run_engine(cfg);
    endtask

    task automatic test_flush();
        read_config_t cfg;
        cfg = '0;
        cfg.array_pointer = 64'h0000_0002_0000_0000;
        cfg.start_read    = 32'd0;
        cfg.end_read      = 32'd30;
        cfg.stride        = 32'd1;
        cfg.flush_mode    = 1'b1;
        run_engine(cfg);
    endtask

    // Slow random acks fill the buffer past threshold
    task automatic test_backpressure_pause();
        read_config_t cfg;
        cfg = '0;
        cfg.array_pointer = 64'h0000_00ab_cdef_0000;
        cfg.start_read    = 32'd100;
        cfg.end_read      = 32'd160;
        cfg.stride        = 32'd2;
        cfg.shift_dir     = SHIFT_LEFT;
        cfg.shift_amount  = 5'd4;
        random_delay = 1'b1;
        fork
            run_engine(cfg);
            begin
                repeat (60) @(posedge ap_clk);
                #1 pause = 1'b1;
                repeat (30) @(posedge ap_clk);
                #1 pause = 1'b0;
            end
        join
        random_delay = 1'b0;
    endtask

    task automatic test_empty_then_rerun();
        read_config_t cfg;
        cfg = '0;
        cfg.array_pointer = 64'h0000_0000_0000_1000;
        cfg.start_read    = 32'd20;
        cfg.end_read      = 32'd20;
        cfg.stride        = 32'd1;
        cfg.shift_dir     = SHIFT_LEFT;
        run_engine(cfg);
        cfg.start_read = 32'd7;
        cfg.end_read   = 32'd12;
        cfg.stride     = 32'd2;
        run_engine(cfg);
    endtask

    initial begin
        areset_engine  = 1'b1;
        engine_config  = '0;
        start          = 1'b0;
        pause          = 1'b0;
        mem_ack        = 1'b0;
        acks_done      = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        random_delay   = 1'b0;
        fixed_delay    = 2;
        test_reset();
        test_linear_left();
        test_right_stride();
        test_flush();
        test_backpressure_pause();
        test_empty_then_rerun();
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: design/serial_read_engine.sv
// Serial read engine top; config must stay stable while start is high

`timescale 1ns/1ps

module serial_read_engine (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  read_config_pkg::read_config_t    engine_config,
    input  logic                             start,
    input  logic                             pause,
    input  logic                             mem_ack,
    output logic                             mem_req,
    output memory_request_pkg::mem_request_t mem_request,
    output logic                             ready,
    output logic                             done
);
    import memory_request_pkg::*;

    mem_request_t push_request;
    mem_request_t head_request;
    logic         push;
    logic         pop;
    logic         valid;
    logic         empty;
    logic         prog_full;
    logic         issue_idle;

    // ----------------------------------------
    // Producer
    // ----------------------------------------
    read_sequencer i_read_sequencer (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .engine_config (engine_config),
        .start         (start),
        .pause         (pause),
        .prog_full     (prog_full),
        .empty         (empty),
        .issue_idle    (issue_idle),
        .push          (push),
        .push_request  (push_request),
        .ready         (ready),
        .done          (done)
    );

    request_fifo i_request_fifo (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .push          (push),
        .push_request  (push_request),
        .pop           (pop),
        .head_request  (head_request),
        .valid         (valid),
        .empty         (empty),
        .prog_full     (prog_full)
    );

    // ----------------------------------------
    // Consumer toward memory
    // ----------------------------------------
    request_issuer i_request_issuer (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .valid         (valid),
        .head_request  (head_request),
        .mem_ack       (mem_ack),
        .pop           (pop),
        .mem_req       (mem_req),
        .mem_request   (mem_request),
        .issue_idle    (issue_idle)
    );

endmodule

// File: design/request_issuer.sv
// Four-phase memory issuer; memory must hold mem_ack high until mem_req drops

`timescale 1ns/1ps

module request_issuer (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             valid,
    input  memory_request_pkg::mem_request_t head_request,
    input  logic                             mem_ack,
    output logic                             pop,
    output logic                             mem_req,
    output memory_request_pkg::mem_request_t mem_request,
    output logic                             issue_idle
);

    typedef enum logic [1:0] {
        ISS_IDLE         = 2'd0,
        ISS_WAIT_ACK     = 2'd1,
        ISS_WAIT_RELEASE = 2'd2
    } issue_state_t;

    issue_state_t state;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state   <= ISS_IDLE;
            pop     <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                ISS_IDLE: begin
                    // Head taken during the pop cycle
                    if (pop) begin
                        mem_req <= 1'b1;
                        state   <= ISS_WAIT_ACK;
                    end else if (valid) begin
                        pop <= 1'b1;
                    end
                end
                ISS_WAIT_ACK: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ISS_WAIT_RELEASE;
                    end
                end
                ISS_WAIT_RELEASE: begin
                    if (!mem_ack) begin
                        state <= ISS_IDLE;
                    end
                end
                default: begin
                    state <= ISS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            mem_request <= head_request;
        end
    end

    assign issue_idle = (state == ISS_IDLE) && !pop;

    assert property (@(posedge ap_clk) disable iff (areset_engine)
        mem_req && $past(mem_req) |-> $stable(mem_request))
        else $error("request_issuer changed mem_request during mem_req");

endmodule

// File: design/request_fifo.sv
// Show-ahead request buffer; depth must be a power of two above the threshold

`timescale 1ns/1ps

`include "read_engine_macros.svh"

module request_fifo (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             push,
    input  memory_request_pkg::mem_request_t push_request,
    input  logic                             pop,
    output memory_request_pkg::mem_request_t head_request,
    output logic                             valid,
    output logic                             empty,
    output logic                             prog_full
);
    import memory_request_pkg::*;

    localparam int depth      = `READ_ENGINE_FIFO_DEPTH;
    localparam int prog_level = `READ_ENGINE_PROG_FULL;
    localparam int ptr_width  = $clog2(depth);

    mem_request_t         entries [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 full;
    logic                 push_ok;
    logic                 pop_ok;

    assign full    = (count == (ptr_width + 1)'(depth));
    assign empty   = (count == '0);
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            entries[wr_ptr] <= push_request;
        end
    end

    // Pointers wrap naturally at the power of two depth
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is shown ahead of the pop
    assign head_request = entries[rd_ptr];
    assign valid        = !empty;
    assign prog_full    = (count >= (ptr_width + 1)'(prog_level));

    assert property (@(posedge ap_clk) disable iff (areset_engine) push |-> !full)
        else $error("request_fifo push while full");

    assert property (@(posedge ap_clk) disable iff (areset_engine) pop |-> !empty)
        else $error("request_fifo pop while empty");

endmodule

// File: design/read_sequencer.sv
// Needs config stable while start is high, a nonzero stride and no index wrap past 2**32

`timescale 1ns/1ps

`include "read_engine_macros.svh"

module read_sequencer (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  read_config_pkg::read_config_t    engine_config,
    input  logic                             start,
    input  logic                             pause,
    input  logic                             prog_full,
    input  logic                             empty,
    input  logic                             issue_idle,
    output logic                             push,
    output memory_request_pkg::mem_request_t push_request,
    output logic                             ready,
    output logic                             done
);
    import read_config_pkg::*;
    import memory_request_pkg::*;

    localparam int addr_width = `READ_ENGINE_ADDR_WIDTH;
    localparam int line_log   = `READ_ENGINE_LINE_SIZE_LOG;
    localparam int ways_log   = `READ_ENGINE_CACHE_WAYS_LOG;

    sequencer_state_t        state;
    sequencer_state_t        next_state;
    read_config_t            config_reg;
    read_index_t             index;
    logic                    start_reg;
    logic                    pause_reg;
    logic                    index_done;
    logic                    drained;
    logic                    push_next;
    logic [addr_width-1:0]   index_wide;
    logic [addr_width-1:0]   line_wide;
    logic [addr_width-1:0]   way_wide;
    logic [addr_width-1:0]   offset;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            start_reg <= 1'b0;
            pause_reg <= 1'b0;
        end else begin
            start_reg <= start;
            pause_reg <= pause;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == SEQ_SETUP) begin
            config_reg <= engine_config;
        end
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    assign index_done = (index.linear >= config_reg.end_read);
    // Nothing in flight toward memory
    assign drained    = !push && empty && issue_idle;
    assign push_next  = (state == SEQ_BUSY) && !index_done && !pause_reg && !prog_full;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= SEQ_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SEQ_RESET: begin
                next_state = SEQ_IDLE;
            end
            SEQ_IDLE: begin
                if (start_reg) begin
                    next_state = SEQ_SETUP;
                end
            end
            SEQ_SETUP: begin
                next_state = SEQ_BUSY;
            end
            SEQ_BUSY: begin
                if (index_done) begin
                    if (drained) begin
                        next_state = SEQ_DONE;
                    end
                end else if (pause_reg || prog_full) begin
                    next_state = SEQ_PAUSE;
                end
            end
            SEQ_PAUSE: begin
                if (!pause_reg && !prog_full) begin
                    next_state = SEQ_BUSY;
                end
            end
            SEQ_DONE: begin
                // Hold done until start drops
                if (!start_reg) begin
                    next_state = SEQ_IDLE;
                end
            end
            default: begin
                next_state = SEQ_RESET;
            end
        endcase
    end

    // Index loads in setup and steps by stride per push
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            index <= '0;
        end else if (state == SEQ_SETUP) begin
            index.linear <= engine_config.start_read;
        end else if (push_next) begin
            index.linear <= index.linear + config_reg.stride;
        end
    end

    // ----------------------------------------
    // Offset generation
    // ----------------------------------------
    assign index_wide = addr_width'(index.linear);
    assign line_wide  = addr_width'(index.flush.line);
    assign way_wide   = addr_width'(index.flush.way);

    always_comb begin
        if (config_reg.flush_mode) begin
            offset = (line_wide << (line_log + ways_log)) | (way_wide << line_log);
        end else if (config_reg.shift_dir == SHIFT_LEFT) begin
            offset = index_wide << config_reg.shift_amount;
        end else begin
            offset = index_wide >> config_reg.shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push <= 1'b0;
        end else begin
            push <= push_next;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push_next) begin
            push_request.base   <= config_reg.array_pointer;
            push_request.offset <= offset;
            push_request.data   <= index.linear;
        end
    end

    assign ready = (state == SEQ_IDLE);
    assign done  = (state == SEQ_DONE);

    // Done only once the buffer and the issuer have drained
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        done |-> empty && issue_idle)
        else $error("read_sequencer raised done with requests in flight");

    // Config must hold while start is high
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        start && $past(start) |-> $stable(engine_config))
        else $error("read_sequencer saw config change while start was high");

endmodule

// File: design/memory_request_pkg.sv
// Memory request types; index width must exceed the cache ways log

`include "read_engine_macros.svh"

package memory_request_pkg;

    // ----------------------------------------
    // Index seen as cache line and way
    // ----------------------------------------
    typedef struct packed {
        logic [`READ_ENGINE_INDEX_WIDTH-`READ_ENGINE_CACHE_WAYS_LOG-1:0] line;
        logic [`READ_ENGINE_CACHE_WAYS_LOG-1:0]                          way;
    } flush_index_t;

    // Same index word read linearly or as line and way
    typedef union packed {
        logic [`READ_ENGINE_INDEX_WIDTH-1:0] linear;
        flush_index_t                        flush;
    } read_index_t;

    // ----------------------------------------
    // One memory read request
    // ----------------------------------------
    typedef struct packed {
        // Array base pointer
        logic [`READ_ENGINE_ADDR_WIDTH-1:0]  base;
        // Byte offset from base
        logic [`READ_ENGINE_ADDR_WIDTH-1:0]  offset;
        // Index that produced the request
        logic [`READ_ENGINE_INDEX_WIDTH-1:0] data;
    } mem_request_t;

endpackage

// File: design/read_config_pkg.sv
// Configuration types for the read engine; field widths come from the macro header

`include "read_engine_macros.svh"

package read_config_pkg;

    // ----------------------------------------
    // Offset shift direction
    // ----------------------------------------
    typedef enum logic {
        SHIFT_RIGHT = 1'b0,
        SHIFT_LEFT  = 1'b1
    } shift_dir_t;

    // ----------------------------------------
    // Run configuration
    // ----------------------------------------
    typedef struct packed {
        logic [`READ_ENGINE_ADDR_WIDTH-1:0]  array_pointer;
        logic [`READ_ENGINE_INDEX_WIDTH-1:0] start_read;
        logic [`READ_ENGINE_INDEX_WIDTH-1:0] end_read;
        logic [`READ_ENGINE_INDEX_WIDTH-1:0] stride;
        shift_dir_t                          shift_dir;
        logic [`READ_ENGINE_SHIFT_WIDTH-1:0] shift_amount;
        // Cache line and way offsets instead of shifted index
        logic                                flush_mode;
    } read_config_t;

    // Sequencer control states
    typedef enum logic [2:0] {
        SEQ_RESET = 3'd0,
        SEQ_IDLE  = 3'd1,
        SEQ_SETUP = 3'd2,
        SEQ_BUSY  = 3'd3,
        SEQ_PAUSE = 3'd4,
        SEQ_DONE  = 3'd5
    } sequencer_state_t;

endpackage

// File: include/read_engine_macros.svh
// Widths and sizes shared by the read engine; FIFO depth must be a power of two

`ifndef READ_ENGINE_MACROS_SVH
`define READ_ENGINE_MACROS_SVH

// Index counter, start, end and stride width
`define READ_ENGINE_INDEX_WIDTH 32

// Base address and byte offset width
`define READ_ENGINE_ADDR_WIDTH 64

// Request buffer geometry
`define READ_ENGINE_FIFO_DEPTH 16
`define READ_ENGINE_PROG_FULL 8

// Cache layout used by flush mode
`define READ_ENGINE_CACHE_WAYS_LOG 2
`define READ_ENGINE_LINE_SIZE_LOG 6

// Shift amount applied to the index
`define READ_ENGINE_SHIFT_WIDTH 5

`endif
